//--- design/vdp_pkg.sv
package vdp_pkg;

   ////////////////////////////////////////
   // Lane geometry

   localparam int VLANE_NUM  = 8;
   localparam int LANE_IDX_W = 3;
   localparam int WORD_W     = 32;
   localparam int BYTE_W     = 8;
   localparam int HALF_BYTES = 2;
   localparam int HALF_W     = HALF_BYTES * BYTE_W;
   localparam int WORD_BYTES = WORD_W / BYTE_W;
   localparam int BYTE_IDX_W = 2;
   localparam int GRP16_NUM  = VLANE_NUM / HALF_BYTES;  // Lane pairs
   localparam int GRP32_NUM  = VLANE_NUM / WORD_BYTES;  // Lane quads
   localparam int IMM_W      = 5;

   ////////////////////////////////////////
   // Control codes

   localparam int SEW_W = 2;
   localparam int OP_W  = 3;
   localparam int SEL_W = 2;

   localparam logic [SEW_W-1:0] SEW_8  = 2'd0;
   localparam logic [SEW_W-1:0] SEW_16 = 2'd1;
   localparam logic [SEW_W-1:0] SEW_32 = 2'd2;  // Code 3 illegal

   localparam logic [OP_W-1:0] OP_ADD = 3'd0;
   localparam logic [OP_W-1:0] OP_SUB = 3'd1;
   localparam logic [OP_W-1:0] OP_AND = 3'd2;
   localparam logic [OP_W-1:0] OP_OR  = 3'd3;
   localparam logic [OP_W-1:0] OP_XOR = 3'd4;

   localparam logic [SEL_W-1:0] OP2_VECTOR = 2'd0;
   localparam logic [SEL_W-1:0] OP2_SCALAR = 2'd1;
   localparam logic [SEL_W-1:0] OP2_IMM    = 2'd2;

   // One lane word seen as bytes or as halfwords
   typedef union packed
   {
      logic [WORD_BYTES-1:0][BYTE_W-1:0]          bytes;
      logic [WORD_W/HALF_W-1:0][HALF_W-1:0]       halves;
   } lane_word_u;

endpackage

//--- design/operand_gather.sv
module operand_gather
  (
   input  logic                                               clk_i,
   input  logic                                               rst_i,
   input  logic                                               valid_i,
   input  logic [vdp_pkg::SEW_W-1:0]                          sew_i,
   input  logic [vdp_pkg::OP_W-1:0]                           opmode_i,
   input  logic [vdp_pkg::SEL_W-1:0]                          op2_sel_i,
   input  logic [vdp_pkg::WORD_W-1:0]                         scalar_i,
   input  logic [vdp_pkg::IMM_W-1:0]                          imm_i,
   input  logic [vdp_pkg::VLANE_NUM-1:0][vdp_pkg::WORD_W-1:0] vs1_i,
   input  logic [vdp_pkg::VLANE_NUM-1:0][vdp_pkg::WORD_W-1:0] vs2_i,
   output logic [vdp_pkg::VLANE_NUM-1:0][vdp_pkg::WORD_W-1:0] alu_a_o,
   output logic [vdp_pkg::VLANE_NUM-1:0][vdp_pkg::WORD_W-1:0] alu_b_o,
   output logic                                               alu_vld_o,
   output logic [vdp_pkg::SEW_W-1:0]                          alu_sew_o,
   output logic [vdp_pkg::OP_W-1:0]                           alu_op_o
   );

   // Regroup lane bytes into one element word per ALU
   function automatic logic [vdp_pkg::VLANE_NUM-1:0][vdp_pkg::WORD_W-1:0] gather
     (input logic [vdp_pkg::VLANE_NUM-1:0][vdp_pkg::WORD_W-1:0] vec,
      input logic [vdp_pkg::SEW_W-1:0]                          sew);
      vdp_pkg::lane_word_u [vdp_pkg::VLANE_NUM-1:0] src;
      vdp_pkg::lane_word_u [vdp_pkg::VLANE_NUM-1:0] dst;
      src = vec;
      dst = '0;  // Upper half stays zero at 16 bits
      for (int a = 0; a < vdp_pkg::VLANE_NUM; a++)
      begin
         case (sew)
            vdp_pkg::SEW_16:
               for (int b = 0; b < vdp_pkg::HALF_BYTES; b++)
                  dst[a].bytes[b] = src[(a % vdp_pkg::GRP16_NUM) * vdp_pkg::HALF_BYTES + b]
                                       .bytes[a / vdp_pkg::GRP16_NUM];
            vdp_pkg::SEW_32:
               for (int b = 0; b < vdp_pkg::WORD_BYTES; b++)
                  dst[a].bytes[b] = src[(a % vdp_pkg::GRP32_NUM) * vdp_pkg::WORD_BYTES + b]
                                       .bytes[a / vdp_pkg::GRP32_NUM];
            default:
               dst[a] = src[a];
         endcase
      end
      return dst;
   endfunction

   logic [vdp_pkg::VLANE_NUM-1:0][vdp_pkg::WORD_W-1:0] vs1_g;
   logic [vdp_pkg::VLANE_NUM-1:0][vdp_pkg::WORD_W-1:0] vs2_g;
   logic [vdp_pkg::VLANE_NUM-1:0][vdp_pkg::WORD_W-1:0] op_b;
   logic [vdp_pkg::WORD_W-1:0]                         imm_ext;
   logic [vdp_pkg::WORD_W-1:0]                         base_word;
   logic [vdp_pkg::WORD_W-1:0]                         op2_word;

   assign vs1_g   = gather(vs1_i, sew_i);
   assign vs2_g   = gather(vs2_i, sew_i);
   assign imm_ext = {{(vdp_pkg::WORD_W-vdp_pkg::IMM_W){imm_i[vdp_pkg::IMM_W-1]}}, imm_i};

   ////////////////////////////////////////
   // Second operand

   always_comb
   begin
      base_word = (op2_sel_i == vdp_pkg::OP2_IMM) ? imm_ext : scalar_i;
      case (sew_i)
         vdp_pkg::SEW_8:  op2_word = {vdp_pkg::WORD_BYTES{base_word[vdp_pkg::BYTE_W-1:0]}};
         vdp_pkg::SEW_16: op2_word = {{vdp_pkg::HALF_W{1'b0}}, base_word[vdp_pkg::HALF_W-1:0]};
         default:         op2_word = base_word;
      endcase
      for (int a = 0; a < vdp_pkg::VLANE_NUM; a++)
         op_b[a] = (op2_sel_i == vdp_pkg::OP2_VECTOR) ? vs2_g[a] : op2_word;
   end

   always_ff @(posedge clk_i)
   begin
      if (!rst_i)
         alu_vld_o <= 1'b0;
      else
         alu_vld_o <= valid_i;
   end

   always_ff @(posedge clk_i)
   begin
      if (valid_i)
      begin
         alu_a_o   <= vs1_g;
         alu_b_o   <= op_b;
         alu_sew_o <= sew_i;
         alu_op_o  <= opmode_i;
      end
   end

   a_legal_ctrl: assert property (@(posedge clk_i) disable iff (!rst_i)
      valid_i |-> (sew_i <= vdp_pkg::SEW_32) && (op2_sel_i <= vdp_pkg::OP2_IMM));

endmodule

//--- design/lane_alu.sv
module lane_alu
  (
   input  logic                        clk_i,
   input  logic                        rst_i,
   input  logic                        vld_i,
   input  logic [vdp_pkg::SEW_W-1:0]   sew_i,
   input  logic [vdp_pkg::OP_W-1:0]    op_i,
   input  logic [vdp_pkg::WORD_W-1:0]  a_i,
   input  logic [vdp_pkg::WORD_W-1:0]  b_i,
   output logic [vdp_pkg::WORD_W-1:0]  res_o,
   output logic                        vld_o,
   output logic [vdp_pkg::SEW_W-1:0]   sew_o
   );

   vdp_pkg::lane_word_u         a_u;
   vdp_pkg::lane_word_u         b_u;
   vdp_pkg::lane_word_u         sum_e;
   vdp_pkg::lane_word_u         dif_e;
   logic [vdp_pkg::WORD_W-1:0]  res_d;

   assign a_u = a_i;
   assign b_u = b_i;

   // Carry chain cut at each element boundary
   always_comb
   begin
      sum_e = a_i + b_i;
      dif_e = a_i - b_i;
      if (sew_i == vdp_pkg::SEW_8)
      begin
         for (int i = 0; i < vdp_pkg::WORD_BYTES; i++)
         begin
            sum_e.bytes[i] = a_u.bytes[i] + b_u.bytes[i];
            dif_e.bytes[i] = a_u.bytes[i] - b_u.bytes[i];
         end
      end
      else if (sew_i == vdp_pkg::SEW_16)
      begin
         for (int i = 0; i < vdp_pkg::WORD_W / vdp_pkg::HALF_W; i++)
         begin
            sum_e.halves[i] = a_u.halves[i] + b_u.halves[i];
            dif_e.halves[i] = a_u.halves[i] - b_u.halves[i];
         end
      end
   end

   always_comb
   begin
      case (op_i)
         vdp_pkg::OP_ADD: res_d = sum_e;
         vdp_pkg::OP_SUB: res_d = dif_e;
         vdp_pkg::OP_AND: res_d = a_i & b_i;
         vdp_pkg::OP_OR:  res_d = a_i | b_i;
         vdp_pkg::OP_XOR: res_d = a_i ^ b_i;
         default:         res_d = '0;
      endcase
   end

   always_ff @(posedge clk_i)
   begin
      if (!rst_i)
         vld_o <= 1'b0;
      else
         vld_o <= vld_i;
   end

   always_ff @(posedge clk_i)
   begin
      if (vld_i)
      begin
         res_o <= res_d;
         sew_o <= sew_i;  // Scatter needs width at result stage
      end
   end

   a_op_range: assert property (@(posedge clk_i) disable iff (!rst_i)
      vld_i |-> op_i <= vdp_pkg::OP_XOR);

endmodule

//--- design/slide_crossbar.sv
module slide_crossbar
  (
   input  logic                                               clk_i,
   input  logic                                               rst_i,
   input  logic                                               valid_i,
   input  logic                                               slide_en_i,
   input  logic                                               slide_up_i,
   input  logic [vdp_pkg::LANE_IDX_W-1:0]                     slide_amount_i,
   input  logic [vdp_pkg::BYTE_IDX_W-1:0]                     slide_byte_sel_i,
   input  logic [vdp_pkg::VLANE_NUM-1:0][vdp_pkg::WORD_W-1:0] vs2_i,
   output logic [vdp_pkg::VLANE_NUM-1:0][vdp_pkg::WORD_W-1:0] slide_data_o,
   output logic                                               slide_sel_o
   );

   logic [vdp_pkg::VLANE_NUM-1:0][vdp_pkg::LANE_IDX_W-1:0] src_lane;
   logic [vdp_pkg::VLANE_NUM-1:0][vdp_pkg::WORD_W-1:0]     rot_data;
   logic [vdp_pkg::VLANE_NUM-1:0][vdp_pkg::WORD_W-1:0]     data_q1;
   logic                                                   slide_go;
   logic                                                   sel_q1;

   assign slide_go = valid_i & slide_en_i;

   // Per lane 8:1 mux, index wraps modulo lane count
   always_comb
   begin
      for (int l = 0; l < vdp_pkg::VLANE_NUM; l++)
      begin
         if (slide_up_i)
            src_lane[l] = vdp_pkg::LANE_IDX_W'(l) - slide_amount_i;
         else
            src_lane[l] = vdp_pkg::LANE_IDX_W'(l) + slide_amount_i;
         rot_data[l] = {vdp_pkg::WORD_BYTES{
                          vs2_i[src_lane[l]][slide_byte_sel_i * vdp_pkg::BYTE_W +: vdp_pkg::BYTE_W]}};
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (!rst_i)
      begin
         sel_q1      <= 1'b0;
         slide_sel_o <= 1'b0;
      end
      else
      begin
         sel_q1      <= slide_go;
         slide_sel_o <= sel_q1;
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (slide_go)
         data_q1 <= rot_data;
      if (sel_q1)
         slide_data_o <= data_q1;  // Lines up with ALU stage
   end

   a_slide_qual: assert property (@(posedge clk_i) disable iff (!rst_i)
      slide_en_i |-> valid_i);

endmodule

//--- design/result_scatter.sv
module result_scatter
  (
   input  logic [vdp_pkg::VLANE_NUM-1:0][vdp_pkg::WORD_W-1:0] alu_res_i,
   input  logic [vdp_pkg::SEW_W-1:0]                          sew_i,
   input  logic [vdp_pkg::VLANE_NUM-1:0][vdp_pkg::WORD_W-1:0] slide_data_i,
   input  logic                                               slide_sel_i,
   output logic [vdp_pkg::VLANE_NUM-1:0][vdp_pkg::WORD_W-1:0] res_o
   );

   vdp_pkg::lane_word_u [vdp_pkg::VLANE_NUM-1:0] alu_u;
   vdp_pkg::lane_word_u [vdp_pkg::VLANE_NUM-1:0] w16_u;
   vdp_pkg::lane_word_u [vdp_pkg::VLANE_NUM-1:0] w32_u;

   assign alu_u = alu_res_i;

   ////////////////////////////////////////
   // Inverse of the operand gather

   always_comb
   begin
      for (int l = 0; l < vdp_pkg::VLANE_NUM; l++)
      begin
         for (int p = 0; p < vdp_pkg::WORD_BYTES; p++)
            w32_u[l].bytes[p] = alu_u[p * vdp_pkg::GRP32_NUM + l / vdp_pkg::WORD_BYTES]
                                   .bytes[l % vdp_pkg::WORD_BYTES];
         for (int p = 0; p < vdp_pkg::HALF_BYTES; p++)
         begin
            w16_u[l].bytes[p] = alu_u[p * vdp_pkg::GRP16_NUM + l / vdp_pkg::HALF_BYTES]
                                   .bytes[l % vdp_pkg::HALF_BYTES];
            w16_u[l].bytes[p + vdp_pkg::HALF_BYTES] = w16_u[l].bytes[p];  // Mirror upper half
         end
      end
   end

   always_comb
   begin
      if (slide_sel_i)
         res_o = slide_data_i;
      else
      begin
         case (sew_i)
            vdp_pkg::SEW_16: res_o = w16_u;
            vdp_pkg::SEW_32: res_o = w32_u;
            default:         res_o = alu_res_i;  // Bytes already in place
         endcase
      end
   end

endmodule

//--- design/vec_datapath.sv
module vec_datapath
  (
   input  logic                                               clk_i,
   input  logic                                               rst_i,
   input  logic                                               valid_i,
   input  logic [vdp_pkg::SEW_W-1:0]                          sew_i,
   input  logic [vdp_pkg::OP_W-1:0]                           opmode_i,
   input  logic [vdp_pkg::SEL_W-1:0]                          op2_sel_i,
   input  logic [vdp_pkg::WORD_W-1:0]                         scalar_i,
   input  logic [vdp_pkg::IMM_W-1:0]                          imm_i,
   input  logic [vdp_pkg::VLANE_NUM-1:0][vdp_pkg::WORD_W-1:0] vs1_i,
   input  logic [vdp_pkg::VLANE_NUM-1:0][vdp_pkg::WORD_W-1:0] vs2_i,
   input  logic                                               slide_en_i,
   input  logic                                               slide_up_i,
   input  logic [vdp_pkg::LANE_IDX_W-1:0]                     slide_amount_i,
   input  logic [vdp_pkg::BYTE_IDX_W-1:0]                     slide_byte_sel_i,
   output logic [vdp_pkg::VLANE_NUM-1:0][vdp_pkg::WORD_W-1:0] res_o,
   output logic                                               res_valid_o
   );

   // Stage one outputs
   logic [vdp_pkg::VLANE_NUM-1:0][vdp_pkg::WORD_W-1:0] alu_a;
   logic [vdp_pkg::VLANE_NUM-1:0][vdp_pkg::WORD_W-1:0] alu_b;
   logic                                               alu_vld;
   logic [vdp_pkg::SEW_W-1:0]                          alu_sew;
   logic [vdp_pkg::OP_W-1:0]                           alu_op;

   // Stage two outputs
   logic [vdp_pkg::VLANE_NUM-1:0][vdp_pkg::WORD_W-1:0] alu_res;
   logic [vdp_pkg::VLANE_NUM-1:0]                      res_vld;
   logic [vdp_pkg::VLANE_NUM-1:0][vdp_pkg::SEW_W-1:0]  res_sew;
   logic [vdp_pkg::VLANE_NUM-1:0][vdp_pkg::WORD_W-1:0] slide_data;
   logic                                               slide_sel;

   operand_gather u_gather
     (
      .clk_i     (clk_i),
      .rst_i     (rst_i),
      .valid_i   (valid_i),
      .sew_i     (sew_i),
      .opmode_i  (opmode_i),
      .op2_sel_i (op2_sel_i),
      .scalar_i  (scalar_i),
      .imm_i     (imm_i),
      .vs1_i     (vs1_i),
      .vs2_i     (vs2_i),
      .alu_a_o   (alu_a),
      .alu_b_o   (alu_b),
      .alu_vld_o (alu_vld),
      .alu_sew_o (alu_sew),
      .alu_op_o  (alu_op)
      );

   for (genvar i = 0; i < vdp_pkg::VLANE_NUM; i++)
   begin : gen_alu
      lane_alu u_alu
        (
         .clk_i (clk_i),
         .rst_i (rst_i),
         .vld_i (alu_vld),
         .sew_i (alu_sew),
         .op_i  (alu_op),
         .a_i   (alu_a[i]),
         .b_i   (alu_b[i]),
         .res_o (alu_res[i]),
         .vld_o (res_vld[i]),
         .sew_o (res_sew[i])
         );
   end

   slide_crossbar u_slide
     (
      .clk_i            (clk_i),
      .rst_i            (rst_i),
      .valid_i          (valid_i),
      .slide_en_i       (slide_en_i),
      .slide_up_i       (slide_up_i),
      .slide_amount_i   (slide_amount_i),
      .slide_byte_sel_i (slide_byte_sel_i),
      .vs2_i            (vs2_i),
      .slide_data_o     (slide_data),
      .slide_sel_o      (slide_sel)
      );

   result_scatter u_scatter
     (
      .alu_res_i    (alu_res),
      .sew_i        (res_sew[0]),
      .slide_data_i (slide_data),
      .slide_sel_i  (slide_sel),
      .res_o        (res_o)
      );

   assign res_valid_o = res_vld[0];  // All ALUs run in lockstep

endmodule

//--- bench/tb_vec_datapath.sv
module tb_vec_datapath;

   timeunit 1ns;
   timeprecision 1ps;

   typedef logic [vdp_pkg::VLANE_NUM-1:0][vdp_pkg::WORD_W-1:0] vec_t;

   localparam int RST_CYC   = 2;
   localparam int LAT       = 2;
   localparam int ALU_NUM   = 40;
   localparam int SCI_NUM   = 36;
   localparam int SLIDE_NUM = 64;
   localparam int B2B_NUM   = 30;
   localparam int DRAIN_CYC = LAT + 3;
   localparam int TEST_CYC  = RST_CYC + 4 + 2 * (2 * ALU_NUM + SCI_NUM + SLIDE_NUM)
                              + B2B_NUM + 1 + 5 * DRAIN_CYC;
   localparam int MAX_CYC   = TEST_CYC + 50;

   logic                              clk_i;
   logic                              rst_i;
   logic                              valid_i;
   logic [vdp_pkg::SEW_W-1:0]         sew_i;
   logic [vdp_pkg::OP_W-1:0]          opmode_i;
   logic [vdp_pkg::SEL_W-1:0]         op2_sel_i;
   logic [vdp_pkg::WORD_W-1:0]        scalar_i;
   logic [vdp_pkg::IMM_W-1:0]         imm_i;
   vec_t                              vs1_i;
   vec_t                              vs2_i;
   logic                              slide_en_i;
   logic                              slide_up_i;
   logic [vdp_pkg::LANE_IDX_W-1:0]    slide_amount_i;
   logic [vdp_pkg::BYTE_IDX_W-1:0]    slide_byte_sel_i;
   vec_t                              res_o;
   logic                              res_valid_o;

   vec_t        exp_q[$];
   int          due_q[$];
   int          cyc = 0;
   int          errors = 0;
   int          checks = 0;
   int          failed = 0;
   int          test_err0 = 0;
   int          test_chk0 = 0;
   logic [15:0] lfsr = 16'd80;

   vec_datapath DUT
     (
      .clk_i            (clk_i),
      .rst_i            (rst_i),
      .valid_i          (valid_i),
      .sew_i            (sew_i),
      .opmode_i         (opmode_i),
      .op2_sel_i        (op2_sel_i),
      .scalar_i         (scalar_i),
      .imm_i            (imm_i),
      .vs1_i            (vs1_i),
      .vs2_i            (vs2_i),
      .slide_en_i       (slide_en_i),
      .slide_up_i       (slide_up_i),
      .slide_amount_i   (slide_amount_i),
      .slide_byte_sel_i (slide_byte_sel_i),
      .res_o            (res_o),
      .res_valid_o      (res_valid_o)
      );

   initial
   begin
      clk_i = 1'b0;
      forever
         #2 clk_i = ~clk_i;
   end

   always @(posedge clk_i)
      cyc <= cyc + 1;

   ////////////////////////////////////////
   // Stimulus helpers

   // Taps of x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      logic        fb;
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         fb   = lfsr[0] ^ lfsr[2] ^ lfsr[3] ^ lfsr[5];
         v    = {v[30:0], lfsr[0]};
         lfsr = {fb, lfsr[15:1]};
      end
      return v;
   endfunction

   function automatic vec_t rand_vec();
      vec_t v;
      for (int l = 0; l < vdp_pkg::VLANE_NUM; l++)
         v[l] = rand_bits(32);
      return v;
   endfunction

   // One element op cut to the element width
   function automatic logic [31:0] elem_op(input logic [vdp_pkg::OP_W-1:0] op,
                                           input logic [31:0] x, input logic [31:0] y,
                                           input int w);
      logic [31:0] r;
      logic [31:0] m;
      m = (w >= 32) ? 32'hffff_ffff : (32'd1 << w) - 32'd1;
      case (op)
         vdp_pkg::OP_ADD: r = x + y;
         vdp_pkg::OP_SUB: r = x - y;
         vdp_pkg::OP_AND: r = x & y;
         vdp_pkg::OP_OR:  r = x | y;
         vdp_pkg::OP_XOR: r = x ^ y;
         default:         r = '0;
      endcase
      return r & m;
   endfunction

   function automatic vec_t ref_result(input logic [vdp_pkg::SEW_W-1:0] sew,
                                       input logic [vdp_pkg::OP_W-1:0] op,
                                       input logic [vdp_pkg::SEL_W-1:0] sel,
                                       input logic [31:0] sc, input logic [4:0] im,
                                       input vec_t v1, input vec_t v2,
                                       input logic slide, input logic up,
                                       input logic [2:0] amt, input logic [1:0] bsel);
      vec_t        r;
      logic [31:0] x;
      logic [31:0] y;
      logic [31:0] s2;
      int          g;
      int          grp;
      int          pos;
      int          src;
      r  = '0;
      s2 = (sel == vdp_pkg::OP2_IMM) ? {{27{im[4]}}, im} : sc;
      if (slide)
      begin
         for (int l = 0; l < 8; l++)
         begin
            src  = up ? (l - int'(amt) + 8) % 8 : (l + int'(amt)) % 8;
            r[l] = {4{v2[src][bsel * 8 +: 8]}};
         end
      end
      else if (sew == vdp_pkg::SEW_8)
      begin
         for (int l = 0; l < 8; l++)
            for (int k = 0; k < 4; k++)
            begin
               x = {24'd0, v1[l][k * 8 +: 8]};
               y = (sel == vdp_pkg::OP2_VECTOR) ? {24'd0, v2[l][k * 8 +: 8]} : {24'd0, s2[7:0]};
               x = elem_op(op, x, y, 8);
               r[l][k * 8 +: 8] = x[7:0];
            end
      end
      else
      begin
         g = (sew == vdp_pkg::SEW_16) ? 2 : 4;  // Bytes per element
         for (int a = 0; a < 8; a++)
         begin
            grp = a % (8 / g);
            pos = a / (8 / g);
            x   = '0;
            y   = '0;
            for (int b = 0; b < g; b++)
            begin
               x[b * 8 +: 8] = v1[grp * g + b][pos * 8 +: 8];
               y[b * 8 +: 8] = v2[grp * g + b][pos * 8 +: 8];
            end
            if (sel != vdp_pkg::OP2_VECTOR)
               y = (g == 2) ? (s2 & 32'h0000_ffff) : s2;
            x = elem_op(op, x, y, g * 8);
            for (int b = 0; b < g; b++)
               r[grp * g + b][pos * 8 +: 8] = x[b * 8 +: 8];
         end
         if (g == 2)
            for (int l = 0; l < 8; l++)
               r[l][31:16] = r[l][15:0];
      end
      return r;
   endfunction

   task automatic issue_op(input logic [1:0] sew, input logic [2:0] op, input logic [1:0] sel,
                           input logic [4:0] im, input logic slide, input logic up,
                           input logic [2:0] amt, input logic [1:0] bsel);
      vec_t        a;
      vec_t        b;
      logic [31:0] sc;
      a  = rand_vec();
      b  = rand_vec();
      sc = rand_bits(32);
      @(posedge clk_i);
      valid_i          <= 1'b1;
      sew_i            <= sew;
      opmode_i         <= op;
      op2_sel_i        <= sel;
      scalar_i         <= sc;
      imm_i            <= im;
      vs1_i            <= a;
      vs2_i            <= b;
      slide_en_i       <= slide;
      slide_up_i       <= up;
      slide_amount_i   <= amt;
      slide_byte_sel_i <= bsel;
      exp_q.push_back(ref_result(sew, op, sel, sc, im, a, b, slide, up, amt, bsel));
      due_q.push_back(cyc + LAT + 1);  // Sampled on the next edge
   endtask

   task automatic idle_cycle();
      @(posedge clk_i);
      valid_i    <= 1'b0;
      slide_en_i <= 1'b0;
   endtask

   task automatic end_test(input int num, input string name);
      while (due_q.size() != 0)
         @(negedge clk_i);
      @(posedge clk_i);
      $display("Test %0d %s: %0d checks, %0d errors", num, name,
               checks - test_chk0, errors - test_err0);
      if (errors != test_err0)
         failed++;
      test_err0 = errors;
      test_chk0 = checks;
   endtask

   ////////////////////////////////////////
   // Result comparison

   initial
   begin
      vec_t exp_v;
      int   due_c;
      forever
      begin
         @(negedge clk_i);
         if (res_valid_o === 1'b1)
         begin
            if (exp_q.size() == 0)
            begin
               $display("Result valid at %0t ns with no operation outstanding", $time);
               errors++;
            end
            else
            begin
               exp_v = exp_q.pop_front();
               due_c = due_q.pop_front();
               checks++;
               if (due_c != cyc)
               begin
                  $display("Result at %0t ns came in cycle %0d, due in cycle %0d",
                           $time, cyc, due_c);
                  errors++;
               end
               if (res_o !== exp_v)
               begin
                  $display("ERROR at %0t ns: res_o = %h, expected %h", $time, res_o, exp_v);
                  errors++;
               end
            end
         end
         else if (due_q.size() != 0 && due_q[0] <= cyc)
         begin
            $display("No valid result at %0t ns for the operation due in cycle %0d",
                     $time, due_q[0]);
            errors++;
            exp_v = exp_q.pop_front();
            due_c = due_q.pop_front();
         end
      end
   end

   initial
   begin
      while (cyc < MAX_CYC)
         @(posedge clk_i);
      $display("Run stopped at cycle %0d with results still outstanding", cyc);
      $display("Errors found");
      $finish;
   end

   ////////////////////////////////////////
   // Test sequence

   initial
   begin
      logic [1:0] sew;
      logic [1:0] sel;
      logic [2:0] op;
      rst_i            <= 1'b0;
      valid_i          <= 1'b0;
      sew_i            <= vdp_pkg::SEW_32;
      opmode_i         <= vdp_pkg::OP_ADD;
      op2_sel_i        <= vdp_pkg::OP2_VECTOR;
      scalar_i         <= '0;
      imm_i            <= '0;
      vs1_i            <= '0;
      vs2_i            <= '0;
      slide_en_i       <= 1'b0;
      slide_up_i       <= 1'b0;
      slide_amount_i   <= '0;
      slide_byte_sel_i <= '0;

      for (int i = 1; i <= RST_CYC + 4; i++)
      begin
         @(posedge clk_i);
         if (i == RST_CYC)
            rst_i <= 1'b1;  // Last reset edge
         @(negedge clk_i);
         checks++;
         if (res_valid_o !== 1'b0)
         begin
            $display("ERROR at %0t ns: res_valid_o = %b, expected 0", $time, res_valid_o);
            errors++;
         end
      end
      end_test(1, "reset");

      for (int i = 0; i < ALU_NUM; i++)
      begin
         issue_op(vdp_pkg::SEW_32, 3'(i % 5), vdp_pkg::OP2_VECTOR, 5'(rand_bits(5)),
                  1'b0, 1'b0, 3'd0, 2'd0);
         idle_cycle();
      end
      end_test(2, "32-bit operations");

      for (int i = 0; i < ALU_NUM; i++)
      begin
         sew = (i % 2 == 0) ? vdp_pkg::SEW_8 : vdp_pkg::SEW_16;
         issue_op(sew, 3'((i / 2) % 5), vdp_pkg::OP2_VECTOR, 5'(rand_bits(5)),
                  1'b0, 1'b0, 3'd0, 2'd0);
         idle_cycle();
      end
      end_test(3, "16-bit and 8-bit operations");

      for (int i = 0; i < SCI_NUM; i++)
      begin
         sel = ((i / 3) % 2 == 0) ? vdp_pkg::OP2_SCALAR : vdp_pkg::OP2_IMM;
         issue_op(2'(i % 3), 3'(i % 5), sel, {1'b1, 4'(rand_bits(4))},
                  1'b0, 1'b0, 3'd0, 2'd0);
         idle_cycle();
      end
      end_test(4, "scalar and immediate operands");

      for (int up = 0; up < 2; up++)
         for (int amt = 0; amt < 8; amt++)
            for (int bs = 0; bs < 4; bs++)
            begin
               issue_op(vdp_pkg::SEW_32, vdp_pkg::OP_ADD, vdp_pkg::OP2_VECTOR,
                        5'(rand_bits(5)), 1'b1, 1'(up), 3'(amt), 2'(bs));
               idle_cycle();
            end
      end_test(5, "slides");

      // Two operations in flight every cycle
      for (int i = 0; i < B2B_NUM; i++)
      begin
         sew = 2'(rand_bits(2) % 3);
         op  = 3'(rand_bits(3) % 5);
         sel = 2'(rand_bits(2) % 3);
         issue_op(sew, op, sel, 5'(rand_bits(5)), 1'(rand_bits(1)), 1'(rand_bits(1)),
                  3'(rand_bits(3)), 2'(rand_bits(2)));
      end
      idle_cycle();
      end_test(6, "back-to-back issue");

      $display("Tests run 6, failed %0d, checks %0d, errors %0d", failed, checks, errors);
      if (errors == 0)
         $display("No errors");
      else
         $display("Errors found");
      $finish;
   end

endmodule

//--- sources.f
design/vdp_pkg.sv
design/operand_gather.sv
design/lane_alu.sv
design/slide_crossbar.sv
design/result_scatter.sv
design/vec_datapath.sv
bench/tb_vec_datapath.sv

//--- run.sh
#!/bin/sh
# Build and run the vector datapath testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
   --top-module tb_vec_datapath -f sources.f -o tb_vec_datapath > build.log 2>&1
if [ $? -ne 0 ]; then
   cat build.log
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/tb_vec_datapath > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "Errors found" sim.log; then
   exit 1
fi
exit 0
